// ==== Makefile ====
# Verilator build and run for the rib bus switch

VERILATOR ?= verilator
TOP       ?= rib_tb
FILELIST  ?= rib.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# the binary exits nonzero on $fatal, so make fails with it
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/rib.sv ====
`timescale 1ns/100ps
`default_nettype none

module rib (
    // masters: 0 data, 1 instruction fetch, 2 and 3 peripherals / debug
    input  wire  rib_pkg::addr_t [rib_pkg::NUM_MASTERS-1:0]  m_addr_i,
    input  wire  rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0]  m_wdata_i,
    input  wire  [rib_pkg::NUM_MASTERS-1:0]                  m_we_i,
    input  wire  [rib_pkg::NUM_MASTERS-1:0]                  m_req_i,
    output rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0]        m_rdata_o,

    // slaves, one per address region
    output rib_pkg::addr_t [rib_pkg::NUM_SLAVES-1:0]         s_addr_o,
    output rib_pkg::data_t [rib_pkg::NUM_SLAVES-1:0]         s_wdata_o,
    output logic [rib_pkg::NUM_SLAVES-1:0]                   s_we_o,
    input  wire  rib_pkg::data_t [rib_pkg::NUM_SLAVES-1:0]   s_rdata_i,

    output logic                                             hold_o      // pipeline stall
);

    rib_pkg::master_idx_t grant;      // current bus owner
    rib_pkg::addr_t       sel_addr;   // owner's address
    rib_pkg::data_t       sel_wdata;  // owner's write data
    logic                 sel_we;     // owner's write enable
    rib_pkg::data_t       sel_rdata;  // addressed slave's read data
    logic                 sel_hit;    // address fell in region 0..5

    rib_arbiter u_arbiter (
        .req_i   (m_req_i),
        .grant_o (grant),
        .hold_o  (hold_o)
    );

    rib_master_mux u_master_mux (
        .grant_i     (grant),
        .m_addr_i    (m_addr_i),
        .m_wdata_i   (m_wdata_i),
        .m_we_i      (m_we_i),
        .m_rdata_o   (m_rdata_o),
        .sel_addr_o  (sel_addr),
        .sel_wdata_o (sel_wdata),
        .sel_we_o    (sel_we),
        .sel_rdata_i (sel_rdata),
        .sel_hit_i   (sel_hit)
    );

    rib_slave_decode u_slave_decode (
        .sel_addr_i  (sel_addr),
        .sel_wdata_i (sel_wdata),
        .sel_we_i    (sel_we),
        .sel_rdata_o (sel_rdata),
        .sel_hit_o   (sel_hit),
        .s_addr_o    (s_addr_o),
        .s_wdata_o   (s_wdata_o),
        .s_we_o      (s_we_o),
        .s_rdata_i   (s_rdata_i)
    );

endmodule

`default_nettype wire

// ==== design/rib_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module rib_arbiter (
    input  wire  [rib_pkg::NUM_MASTERS-1:0] req_i,      // one request level per master
    output rib_pkg::master_idx_t            grant_o,    // master that owns the bus
    output logic                            hold_o      // stall the pipeline
);

    logic any_data_req;    // a non-fetch master is asking

    // fixed priority, highest first: 3, 0, 2, 1
    always_comb begin
        if (req_i[3]) begin
            grant_o = rib_pkg::master_idx_t'(3);
        end else if (req_i[0]) begin
            grant_o = rib_pkg::master_idx_t'(0);
        end else if (req_i[2]) begin
            grant_o = rib_pkg::master_idx_t'(2);
        end else begin
            // fetch port keeps the bus, asking or not
            grant_o = rib_pkg::master_idx_t'(rib_pkg::FETCH_MASTER);
        end
    end

    // req_i[1] never stalls, fetch is the default owner anyway
    assign any_data_req = req_i[3] | req_i[0] | req_i[2];
    assign hold_o       = any_data_req;

endmodule

`default_nettype wire

// ==== design/rib_master_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module rib_master_mux (
    input  wire  rib_pkg::master_idx_t                        grant_i,     // from the arbiter

    // master side, indexed by master number
    input  wire  rib_pkg::addr_t [rib_pkg::NUM_MASTERS-1:0]   m_addr_i,
    input  wire  rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0]   m_wdata_i,
    input  wire  [rib_pkg::NUM_MASTERS-1:0]                   m_we_i,
    output rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0]         m_rdata_o,

    // toward the slave decoder
    output rib_pkg::addr_t                                    sel_addr_o,
    output rib_pkg::data_t                                    sel_wdata_o,
    output logic                                              sel_we_o,
    input  wire  rib_pkg::data_t                              sel_rdata_i,
    input  wire                                               sel_hit_i    // region 0..5
);

    rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0] idle_rdata;   // per-master idle value

    // request path, granted master only
    assign sel_addr_o  = m_addr_i[grant_i];
    assign sel_wdata_o = m_wdata_i[grant_i];
    assign sel_we_o    = m_we_i[grant_i];

    // fetch port idles on a NOP so the core never sees garbage opcodes
    for (genvar m = 0; m < rib_pkg::NUM_MASTERS; m++) begin : g_idle
        if (m == rib_pkg::FETCH_MASTER) begin : g_fetch
            assign idle_rdata[m] = rib_pkg::INST_NOP;
        end else begin : g_data
            assign idle_rdata[m] = '0;
        end
    end

    // read return path
    always_comb begin
        m_rdata_o = idle_rdata;
        if (sel_hit_i) begin
            m_rdata_o[grant_i] = sel_rdata_i;    // unused region keeps idle value
        end
    end

endmodule

`default_nettype wire

// ==== design/rib_pkg.sv ====
`default_nettype none

package rib_pkg;

    // bus geometry
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int REGION_W = 4;                    // top address bits pick the slave
    localparam int OFFSET_W = ADDR_W - REGION_W;    // 28 bits left for the slave

    // port counts
    localparam int NUM_MASTERS = 4;
    localparam int NUM_SLAVES  = 6;                 // regions 6..15 are unused

    // instruction fetch port, also owns the bus when nobody asks
    localparam int FETCH_MASTER = 1;

    // addi x0, x0, 0
    localparam logic [DATA_W-1:0] INST_NOP = 32'h0000_0013;

    // vector types
    typedef logic [ADDR_W-1:0]   addr_t;            // bus address
    typedef logic [DATA_W-1:0]   data_t;            // bus data word
    typedef logic [REGION_W-1:0] region_t;          // slave region number
    typedef logic [1:0]          master_idx_t;      // granted master

endpackage

`default_nettype wire

// ==== design/rib_slave_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rib_slave_decode (
    // granted request from the master mux
    input  wire  rib_pkg::addr_t                             sel_addr_i,
    input  wire  rib_pkg::data_t                             sel_wdata_i,
    input  wire                                              sel_we_i,
    output rib_pkg::data_t                                   sel_rdata_o,
    output logic                                             sel_hit_o,    // some slave matched

    // slave side, indexed by slave number
    output rib_pkg::addr_t [rib_pkg::NUM_SLAVES-1:0]         s_addr_o,
    output rib_pkg::data_t [rib_pkg::NUM_SLAVES-1:0]         s_wdata_o,
    output logic [rib_pkg::NUM_SLAVES-1:0]                   s_we_o,
    input  wire  rib_pkg::data_t [rib_pkg::NUM_SLAVES-1:0]   s_rdata_i
);

    rib_pkg::region_t                 region;      // top address field
    logic [rib_pkg::OFFSET_W-1:0]     offset;      // rest of the address
    rib_pkg::addr_t                   slave_addr;  // offset with region cleared
    logic [rib_pkg::NUM_SLAVES-1:0]   slave_sel;   // one-hot slave select

    assign region     = sel_addr_i[rib_pkg::ADDR_W-1 -: rib_pkg::REGION_W];
    assign offset     = sel_addr_i[rib_pkg::OFFSET_W-1:0];
    assign slave_addr = {{rib_pkg::REGION_W{1'b0}}, offset};

    // regions 6..15 reach nobody
    assign sel_hit_o = (region < rib_pkg::REGION_W'(rib_pkg::NUM_SLAVES));

    for (genvar s = 0; s < rib_pkg::NUM_SLAVES; s++) begin : g_slave
        assign slave_sel[s] = sel_hit_o && (region == rib_pkg::region_t'(s));

        // unselected slaves see an all-zero bus
        assign s_addr_o[s]  = slave_sel[s] ? slave_addr  : '0;
        assign s_wdata_o[s] = slave_sel[s] ? sel_wdata_i : '0;
        assign s_we_o[s]    = slave_sel[s] & sel_we_i;
    end

    // select is one-hot, so an OR of the gated words is enough
    always_comb begin
        sel_rdata_o = '0;
        for (int s = 0; s < rib_pkg::NUM_SLAVES; s++) begin
            sel_rdata_o |= slave_sel[s] ? s_rdata_i[s] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rib.f ====
design/rib_pkg.sv
design/rib_arbiter.sv
design/rib_master_mux.sv
design/rib_slave_decode.sv
design/rib.sv
test/rib_assert.sv
test/rib_tb.sv

// ==== test/rib_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module rib_assert (
    input wire                                             clk_i,
    input wire                                             arst_n_i,
    input wire rib_pkg::addr_t [rib_pkg::NUM_MASTERS-1:0]  m_addr_i,
    input wire [rib_pkg::NUM_MASTERS-1:0]                  m_req_i,
    input wire rib_pkg::addr_t [rib_pkg::NUM_SLAVES-1:0]   s_addr_i,
    input wire [rib_pkg::NUM_SLAVES-1:0]                   s_we_i,
    input wire                                             hold_i
);

    rib_pkg::region_t                 fetch_region;   // region the fetch port points at
    logic [rib_pkg::NUM_SLAVES-1:0]   fetch_sel;      // zero for regions 6..15

    assign fetch_region = m_addr_i[rib_pkg::FETCH_MASTER][rib_pkg::ADDR_W-1 -: rib_pkg::REGION_W];
    assign fetch_sel    = rib_pkg::NUM_SLAVES'(1) << fetch_region;

    a_we_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(s_we_i))
        else $error("more than one slave write enable is high");

    // masters 3, 0 and 2 stall the core, fetch never does
    a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        hold_i == (m_req_i[3] | m_req_i[0] | m_req_i[2]))
        else $error("hold does not follow requests 3, 0 and 2");

    for (genvar s = 0; s < rib_pkg::NUM_SLAVES; s++) begin : g_we_region
        a_we_region: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            s_we_i[s] |-> (s_addr_i[s][rib_pkg::ADDR_W-1 -: rib_pkg::REGION_W] == '0))
            else $error("slave %0d written with a nonzero region field", s);
    end

    a_idle_we: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (m_req_i == '0) |-> ((s_we_i & ~fetch_sel) == '0))
        else $error("unselected slave written while the fetch port owns the bus");

endmodule

`default_nettype wire

// ==== test/rib_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rib_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 2000;
    localparam int SEED         = 36272;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES) * CLK_PERIOD * 2;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;   // addi x0, x0, 0

    logic clk = 1'b0;
    logic arst_n;

    rib_pkg::addr_t [3:0] m_addr;
    rib_pkg::data_t [3:0] m_wdata;
    logic [3:0]           m_we;
    logic [3:0]           m_req;
    rib_pkg::data_t [3:0] m_rdata;
    rib_pkg::addr_t [5:0] s_addr;
    rib_pkg::data_t [5:0] s_wdata;
    logic [5:0]           s_we;
    rib_pkg::data_t [5:0] s_rdata;
    logic                 hold;

    int n_idle   = 0;   // cycles with no request at all
    int n_unused = 0;   // granted address in region 6..15
    int n_writes = 0;   // slave write enables seen

    always #(CLK_PERIOD / 2) clk = ~clk;

    rib dut (
        .m_addr_i  (m_addr),
        .m_wdata_i (m_wdata),
        .m_we_i    (m_we),
        .m_req_i   (m_req),
        .m_rdata_o (m_rdata),
        .s_addr_o  (s_addr),
        .s_wdata_o (s_wdata),
        .s_we_o    (s_we),
        .s_rdata_i (s_rdata),
        .hold_o    (hold)
    );

    bind rib rib_assert u_assert (
        .clk_i    (rib_tb.clk),
        .arst_n_i (rib_tb.arst_n),
        .m_addr_i (m_addr_i),
        .m_req_i  (m_req_i),
        .s_addr_i (s_addr_o),
        .s_we_i   (s_we_o),
        .hold_i   (hold_o)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Something failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // priority 3, 0, 2, then fetch by default
    function automatic int model_grant(input logic [3:0] req);
        if (req[3]) begin
            return 3;
        end else if (req[0]) begin
            return 0;
        end else if (req[2]) begin
            return 2;
        end
        return 1;
    endfunction

    // three in four addresses land on a real slave
    function automatic rib_pkg::addr_t random_addr();
        logic [3:0]  region;
        logic [27:0] offset;
        if ($urandom_range(3, 0) == 0) begin
            region = 4'($urandom_range(15, 6));
        end else begin
            region = 4'($urandom_range(5, 0));
        end
        offset = 28'($urandom);
        return {region, offset};
    endfunction

    task automatic drive_random();
        for (int m = 0; m < 4; m++) begin
            m_addr[m]  <= random_addr();
            m_wdata[m] <= $urandom;
            m_we[m]    <= 1'($urandom);
        end
        m_req <= 4'($urandom);   // all-zero about one cycle in sixteen
        for (int s = 0; s < 6; s++) begin
            s_rdata[s] <= $urandom;
        end
    endtask

    task automatic check_outputs();
        int          g;
        logic [3:0]  region;
        logic        hit;
        logic        sel;
        logic [31:0] exp_rdata;
        g      = model_grant(m_req);
        region = m_addr[g][31:28];
        hit    = (region < 4'd6);
        if (m_req == 4'b0000) n_idle++;
        if (!hit) n_unused++;
        check_value(32'(hold), 32'(m_req[3] | m_req[0] | m_req[2]), "hold");
        for (int s = 0; s < 6; s++) begin
            sel = hit && (region == 4'(s));
            if (s_we[s]) n_writes++;
            check_value(s_addr[s], sel ? {4'h0, m_addr[g][27:0]} : 32'h0,
                        $sformatf("slave %0d address", s));
            check_value(s_wdata[s], sel ? m_wdata[g] : 32'h0,
                        $sformatf("slave %0d write data", s));
            check_value(32'(s_we[s]), 32'(sel & m_we[g]),
                        $sformatf("slave %0d write enable", s));
        end
        for (int m = 0; m < 4; m++) begin
            exp_rdata = (m == 1) ? NOP_WORD : 32'h0;   // idle value
            if (m == g && hit) begin
                exp_rdata = s_rdata[region];
            end
            check_value(m_rdata[m], exp_rdata,
                        $sformatf("master %0d read data (grant %0d)", m, g));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n  = 1'b0;
        m_addr  = '0;
        m_wdata = '0;
        m_we    = '0;
        m_req   = '0;
        s_rdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);   // combinational outputs settled
            check_outputs();
        end
        $display("cycles %0d, idle %0d, unused region %0d, writes %0d",
                 NUM_CYCLES, n_idle, n_unused, n_writes);
        if (n_idle == 0 || n_unused == 0 || n_writes == 0) begin
            $display("Something failed");
            $fatal(1, "random stimulus missed idle, unused region or write cycles");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Something failed");
        $fatal(1, "timeout, the test did not finish within %0d ns", WATCHDOG_NS);
    end

endmodule

`default_nettype wire
